/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

   // datapath and address width
   localparam int xlen = 32;

   // memory depths in words
   localparam int imem_words = 256;
   localparam int dmem_words = 256;

   // word index widths, byte address bits 1:0 dropped
   localparam int imem_addr_bits = 8;
   localparam int dmem_addr_bits = 8;

   // addi x0,x0,0
   // fills squashed slots and pads programs
   localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      opc_lui    = 7'b0110111,
      opc_op_imm = 7'b0010011,
      opc_op     = 7'b0110011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111,
      opc_system = 7'b1110011
   } opcode_e;

   // alu operations
   // the two compare ops only feed branch resolution
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_pass_b,
      alu_beq_cmp,
      alu_bne_cmp
   } alu_op_e;

endpackage

`default_nettype wire

/* src/fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             redirect_i,
   input  logic [rv_pkg::xlen-1:0]          target_i,
   input  logic                             halt_i,
   input  logic                             imem_we_i,
   input  logic [rv_pkg::imem_addr_bits-1:0] imem_addr_i,
   input  logic [rv_pkg::xlen-1:0]          imem_data_i,
   output logic [rv_pkg::xlen-1:0]          pc_o,
   output logic [rv_pkg::xlen-1:0]          instr_o
);
   import rv_pkg::*;

   logic [xlen-1:0] pc_q;
   logic [xlen-1:0] imem [imem_words];

   // program counter
   // halt wins, then redirect, then pc + 4
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= '0;
      end else if (halt_i) begin
         pc_q <= pc_q;
      end else if (redirect_i) begin
         pc_q <= target_i;
      end else begin
         pc_q <= pc_q + 32'd4;
      end
   end

   // program load, only while the core sits in reset
   always_ff @(posedge clk) begin
      if (reset && imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
   end

   // async read, word index from pc
   assign pc_o    = pc_q;
   assign instr_o = imem[pc_q[imem_addr_bits+1:2]];

endmodule

`default_nettype wire

/* src/decode.sv */
`timescale 1ns/1ns
`default_nettype none

module decode (
   input  logic [rv_pkg::xlen-1:0] instr_i,
   output logic [4:0]              rd_o,
   output logic [4:0]              rs1_o,
   output logic [4:0]              rs2_o,
   output logic [rv_pkg::xlen-1:0] imm_o,
   output rv_pkg::alu_op_e         alu_op_o,
   output logic                    use_imm_o,
   output logic                    reg_write_o,
   output logic                    mem_read_o,
   output logic                    mem_write_o,
   output logic                    branch_o,
   output logic                    jump_o,
   output logic                    halt_instr_o
);
   import rv_pkg::*;

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = opcode_e'(instr_i[6:0]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // register fields are fixed in every format
   assign rd_o  = instr_i[11:7];
   assign rs1_o = instr_i[19:15];
   assign rs2_o = instr_i[24:20];

   always_comb begin
      // defaults give a nop with no side effects
      imm_o        = '0;
      alu_op_o     = alu_add;
      use_imm_o    = 1'b0;
      reg_write_o  = 1'b0;
      mem_read_o   = 1'b0;
      mem_write_o  = 1'b0;
      branch_o     = 1'b0;
      jump_o       = 1'b0;
      halt_instr_o = 1'b0;
      case (opcode)
         opc_lui: begin
            // u-type, upper 20 bits
            imm_o       = {instr_i[31:12], 12'b0};
            alu_op_o    = alu_pass_b;
            use_imm_o   = 1'b1;
            reg_write_o = 1'b1;
         end
         opc_op_imm: begin
            // only addi
            imm_o       = {{20{instr_i[31]}}, instr_i[31:20]};
            use_imm_o   = 1'b1;
            reg_write_o = (funct3 == 3'b000);
         end
         opc_op: begin
            reg_write_o = 1'b1;
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: alu_op_o = alu_add;
               {7'b0100000, 3'b000}: alu_op_o = alu_sub;
               {7'b0000000, 3'b111}: alu_op_o = alu_and;
               {7'b0000000, 3'b110}: alu_op_o = alu_or;
               {7'b0000000, 3'b100}: alu_op_o = alu_xor;
               default:              reg_write_o = 1'b0;
            endcase
         end
         opc_load: begin
            // lw only, address = rs1 + i-imm
            imm_o       = {{20{instr_i[31]}}, instr_i[31:20]};
            use_imm_o   = 1'b1;
            reg_write_o = (funct3 == 3'b010);
            mem_read_o  = (funct3 == 3'b010);
         end
         opc_store: begin
            // sw only, s-type split immediate
            imm_o       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            use_imm_o   = 1'b1;
            mem_write_o = (funct3 == 3'b010);
         end
         opc_branch: begin
            // b-type, bit 0 always zero
            imm_o    = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            alu_op_o = (funct3 == 3'b001) ? alu_bne_cmp : alu_beq_cmp;
            branch_o = (funct3 == 3'b000) || (funct3 == 3'b001);
         end
         opc_jal: begin
            // j-type, link written by execute
            imm_o       = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                           instr_i[30:21], 1'b0};
            reg_write_o = 1'b1;
            jump_o      = 1'b1;
         end
         opc_system: begin
            // ebreak: funct12 = 1, all other fields zero
            halt_instr_o = (instr_i[31:7] == 25'h0002000);
         end
         default: begin
            // outside the subset, stays a nop
            reg_write_o = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [4:0]              rs1_i,
   input  logic [4:0]              rs2_i,
   input  logic [4:0]              rd_i,
   input  logic                    we_i,
   input  logic [rv_pkg::xlen-1:0] wd_i,
   output logic [rv_pkg::xlen-1:0] rs1_data_o,
   output logic [rv_pkg::xlen-1:0] rs2_data_o
);
   import rv_pkg::*;

   // x1..x31, x0 has no storage
   logic [xlen-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (rd_i != 5'd0)) begin
         regs[rd_i] <= wd_i;
      end
   end

   // x0 reads zero
   // same-cycle write returns the new value
   always_comb begin
      if (rs1_i == 5'd0) rs1_data_o = '0;
      else if (we_i && (rd_i == rs1_i)) rs1_data_o = wd_i;
      else rs1_data_o = regs[rs1_i];

      if (rs2_i == 5'd0) rs2_data_o = '0;
      else if (we_i && (rd_i == rs2_i)) rs2_data_o = wd_i;
      else rs2_data_o = regs[rs2_i];
   end

endmodule

`default_nettype wire

/* src/execute.sv */
`timescale 1ns/1ns
`default_nettype none

module execute (
   input  logic [rv_pkg::xlen-1:0] pc_i,
   input  logic [rv_pkg::xlen-1:0] op1_i,
   input  logic [rv_pkg::xlen-1:0] op2_i,
   input  logic [rv_pkg::xlen-1:0] imm_i,
   input  rv_pkg::alu_op_e         alu_op_i,
   input  logic                    use_imm_i,
   input  logic                    branch_i,
   input  logic                    jump_i,
   output logic [rv_pkg::xlen-1:0] alu_result_o,
   output logic [rv_pkg::xlen-1:0] target_o,
   output logic                    redirect_o
);
   import rv_pkg::*;

   logic [xlen-1:0] op_b;
   logic [xlen-1:0] alu_out;
   logic            equal;
   logic            cond;

   // second operand: immediate or rs2
   assign op_b  = use_imm_i ? imm_i : op2_i;
   assign equal = (op1_i == op2_i);

   always_comb begin
      cond = 1'b0;
      case (alu_op_i)
         alu_add:    alu_out = op1_i + op_b;
         alu_sub:    alu_out = op1_i - op_b;
         alu_and:    alu_out = op1_i & op_b;
         alu_or:     alu_out = op1_i | op_b;
         alu_xor:    alu_out = op1_i ^ op_b;
         alu_pass_b: alu_out = op_b;
         alu_beq_cmp: begin
            // branches write nothing
            alu_out = '0;
            cond    = equal;
         end
         alu_bne_cmp: begin
            alu_out = '0;
            cond    = !equal;
         end
         default:    alu_out = '0;
      endcase
   end

   // jal writes the link value instead
   assign alu_result_o = jump_i ? (pc_i + 32'd4) : alu_out;

   // branch and jal share pc-relative target
   assign target_o = pc_i + imm_i;

   // jumps always redirect, branches on a true compare
   assign redirect_o = jump_i || (branch_i && cond);

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module data_mem (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [rv_pkg::xlen-1:0] addr_i,
   input  logic [rv_pkg::xlen-1:0] wdata_i,
   input  logic                    write_i,
   output logic [rv_pkg::xlen-1:0] rdata_o
);
   import rv_pkg::*;

   logic [xlen-1:0]           mem [dmem_words];
   logic [dmem_addr_bits-1:0] index;

   // word index, bits 9:2 of the byte address
   assign index = addr_i[dmem_addr_bits+1:2];

   // whole array cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < dmem_words; i++) begin
            mem[i] <= '0;
         end
      end else if (write_i) begin
         mem[index] <= wdata_i;
      end
   end

   // load is combinational
   assign rdata_o = mem[index];

endmodule

`default_nettype wire

/* src/riscv32i.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv32i (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              imem_we_i,
   input  logic [rv_pkg::imem_addr_bits-1:0] imem_addr_i,
   input  logic [rv_pkg::xlen-1:0]           imem_data_i,
   output logic                              retire_valid_o,
   output logic [rv_pkg::xlen-1:0]           retire_pc_o,
   output logic                              retire_we_o,
   output logic [4:0]                        retire_rd_o,
   output logic [rv_pkg::xlen-1:0]           retire_data_o,
   output logic                              store_valid_o,
   output logic [rv_pkg::xlen-1:0]           store_addr_o,
   output logic [rv_pkg::xlen-1:0]           store_data_o,
   output logic                              halt_o
);
   import rv_pkg::*;

   // fetch, decode, reg file, execute, memory outputs
   logic [xlen-1:0] if_pc, if_instr;
   logic [4:0]      id_rd, id_rs1, id_rs2;
   logic [xlen-1:0] id_imm, rf_rs1, rf_rs2;
   alu_op_e         id_alu_op;
   logic            id_use_imm, id_reg_write, id_mem_read, id_mem_write;
   logic            id_branch, id_jump, id_halt;
   logic [xlen-1:0] ex_result, ex_target, dm_rdata;
   logic            ex_redirect;

   // pipeReg0, fetch to decode
   logic            p0_valid;
   logic [xlen-1:0] p0_pc, p0_instr;

   // pipeReg1, decode to execute
   logic            p1_valid, p1_use_imm, p1_reg_write, p1_mem_read, p1_mem_write;
   logic            p1_branch, p1_jump, p1_halt;
   alu_op_e         p1_alu_op;
   logic [4:0]      p1_rd;
   logic [xlen-1:0] p1_pc, p1_op1, p1_op2, p1_imm;

   // pipeReg2, execute to memory
   logic            p2_valid, p2_redirect, p2_reg_write, p2_mem_read, p2_mem_write, p2_halt;
   logic [4:0]      p2_rd;
   logic [xlen-1:0] p2_pc, p2_alu, p2_target, p2_store_data;

   // pipeReg3, memory to write-back
   logic            p3_valid, p3_reg_write, p3_halt;
   logic [4:0]      p3_rd;
   logic [xlen-1:0] p3_pc, p3_result;

   logic flush, wb_we;

   // taken branch or jal in pipeReg2 squashes the two younger slots
   assign flush = p2_redirect;

   fetch fetch_inst (
      .clk(clk), .reset(reset),
      .redirect_i(p2_redirect), .target_i(p2_target), .halt_i(halt_o),
      .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
      .pc_o(if_pc), .instr_o(if_instr)
   );

   decode decode_inst (
      .instr_i(p0_instr),
      .rd_o(id_rd), .rs1_o(id_rs1), .rs2_o(id_rs2), .imm_o(id_imm),
      .alu_op_o(id_alu_op), .use_imm_o(id_use_imm), .reg_write_o(id_reg_write),
      .mem_read_o(id_mem_read), .mem_write_o(id_mem_write),
      .branch_o(id_branch), .jump_o(id_jump), .halt_instr_o(id_halt)
   );

   reg_file reg_file_inst (
      .clk(clk), .reset(reset),
      .rs1_i(id_rs1), .rs2_i(id_rs2), .rd_i(p3_rd), .we_i(wb_we), .wd_i(p3_result),
      .rs1_data_o(rf_rs1), .rs2_data_o(rf_rs2)
   );

   execute execute_inst (
      .pc_i(p1_pc), .op1_i(p1_op1), .op2_i(p1_op2), .imm_i(p1_imm),
      .alu_op_i(p1_alu_op), .use_imm_i(p1_use_imm),
      .branch_i(p1_branch), .jump_i(p1_jump),
      .alu_result_o(ex_result), .target_o(ex_target), .redirect_o(ex_redirect)
   );

   data_mem data_mem_inst (
      .clk(clk), .reset(reset),
      .addr_i(p2_alu), .wdata_i(p2_store_data), .write_i(store_valid_o),
      .rdata_o(dm_rdata)
   );

   // control state, reset and flush here
   // everything freezes once halted
   always_ff @(posedge clk) begin
      if (reset) begin
         p0_valid <= 1'b0;
         p0_instr <= nop_instr;
         p1_valid <= 1'b0;
         {p1_use_imm, p1_reg_write, p1_mem_read, p1_mem_write} <= '0;
         {p1_branch, p1_jump, p1_halt} <= '0;
         p1_alu_op <= alu_add;
         {p2_valid, p2_redirect, p2_reg_write, p2_mem_read, p2_mem_write, p2_halt} <= '0;
         {p3_valid, p3_reg_write, p3_halt} <= '0;
      end else if (!halt_o) begin
         if (flush) begin
            // squashed slots turn into invalid nops
            p0_valid <= 1'b0;
            p0_instr <= nop_instr;
            p1_valid <= 1'b0;
            {p1_use_imm, p1_reg_write, p1_mem_read, p1_mem_write} <= '0;
            {p1_branch, p1_jump, p1_halt} <= '0;
            p1_alu_op <= alu_add;
         end else begin
            p0_valid     <= 1'b1;
            p0_instr     <= if_instr;
            p1_valid     <= p0_valid;
            p1_use_imm   <= id_use_imm;
            p1_reg_write <= id_reg_write;
            p1_mem_read  <= id_mem_read;
            p1_mem_write <= id_mem_write;
            p1_branch    <= id_branch;
            p1_jump      <= id_jump;
            p1_halt      <= id_halt;
            p1_alu_op    <= id_alu_op;
         end
         // pipeReg1 slot moves on even during a flush
         p2_valid     <= p1_valid;
         p2_redirect  <= ex_redirect && p1_valid;
         p2_reg_write <= p1_reg_write;
         p2_mem_read  <= p1_mem_read;
         p2_mem_write <= p1_mem_write;
         p2_halt      <= p1_halt;
         p3_valid     <= p2_valid;
         p3_reg_write <= p2_reg_write;
         p3_halt      <= p2_halt;
      end
   end

   // payload fields, no reset
   always_ff @(posedge clk) begin
      if (!halt_o) begin
         p0_pc         <= if_pc;
         p1_pc         <= p0_pc;
         p1_rd         <= id_rd;
         p1_op1        <= rf_rs1;
         p1_op2        <= rf_rs2;
         p1_imm        <= id_imm;
         p2_pc         <= p1_pc;
         p2_rd         <= p1_rd;
         p2_alu        <= ex_result;
         p2_target     <= ex_target;
         p2_store_data <= p1_op2;
         p3_pc         <= p2_pc;
         p3_rd         <= p2_rd;
         // load data or alu result
         p3_result     <= p2_mem_read ? dm_rdata : p2_alu;
      end
   end

   // ebreak in pipeReg3 holds itself there, so halt stays up
   assign halt_o = p3_valid && p3_halt;

   // write-back, x0 never written
   assign wb_we = p3_valid && p3_reg_write && (p3_rd != 5'd0);

   // ebreak itself does not retire
   assign retire_valid_o = p3_valid && !p3_halt;
   assign retire_pc_o    = p3_pc;
   assign retire_we_o    = wb_we;
   assign retire_rd_o    = p3_rd;
   assign retire_data_o  = p3_result;

   // store seen while in pipeReg2, written at the next edge
   assign store_valid_o = p2_valid && p2_mem_write && !halt_o;
   assign store_addr_o  = p2_alu;
   assign store_data_o  = p2_store_data;

endmodule

`default_nettype wire

/* sim/riscv32i_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv32i_properties (
   input logic clk,
   input logic reset,
   input logic retire_valid_i,
   input logic store_valid_i,
   input logic halt_i,
   input logic redirect_i
);

   // quiet outputs once the first reset edge has passed
   reset_quiet: assert property (@(posedge clk)
      (reset && $past(reset)) |-> (!retire_valid_i && !store_valid_i && !halt_i))
      else $error("retire, store or halt active during reset");

   // halt only clears through reset
   halt_sticky: assert property (@(posedge clk) disable iff (reset) halt_i |=> halt_i)
      else $error("halt dropped without reset");

   // frozen pipeline keeps the ebreak in write-back
   halt_no_retire: assert property (@(posedge clk) disable iff (reset)
      halt_i |=> !retire_valid_i)
      else $error("retire while halted");

   // the two squashed slots reach write-back 3 and 4 cycles after the redirect
   squash_bubbles: assert property (@(posedge clk) disable iff (reset)
      (redirect_i && !halt_i) |-> ##3 !retire_valid_i ##1 !retire_valid_i)
      else $error("squashed slot retired after redirect");

endmodule

`default_nettype wire

/* sim/riscv32i_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv32i_tb;
   import rv_pkg::*;

   // 60 slots of one instruction and three nops, then ebreak and its pad
   localparam int slots      = 60;
   localparam int prog_words = slots * 4 + 4;
   localparam int seed_init  = 96;
   localparam int max_cycles = (prog_words + 10) * 2;

   typedef enum int {
      k_lui, k_addi, k_add, k_sub, k_and, k_or, k_xor, k_lw, k_sw, k_beq, k_bne, k_jal
   } kind_e;

   logic                      clk;
   logic                      reset;
   logic                      imem_we_i;
   logic [imem_addr_bits-1:0] imem_addr_i;
   logic [xlen-1:0]           imem_data_i;
   logic                      retire_valid_o;
   logic [xlen-1:0]           retire_pc_o;
   logic                      retire_we_o;
   logic [4:0]                retire_rd_o;
   logic [xlen-1:0]           retire_data_o;
   logic                      store_valid_o;
   logic [xlen-1:0]           store_addr_o;
   logic [xlen-1:0]           store_data_o;
   logic                      halt_o;

   integer          seed;
   int              cycles;
   int              retire_seen;
   int              model_retires;

   // per-slot instruction fields, shared by generator and model
   kind_e           kind [slots];
   logic [4:0]      f_rd [slots];
   logic [4:0]      f_rs1 [slots];
   logic [4:0]      f_rs2 [slots];
   logic [xlen-1:0] f_imm [slots];
   logic [xlen-1:0] prog [prog_words];

   // expected events in order
   logic [xlen-1:0] exp_pc [$];
   logic            exp_we [$];
   logic [4:0]      exp_rd [$];
   logic [xlen-1:0] exp_data [$];
   logic [xlen-1:0] exp_saddr [$];
   logic [xlen-1:0] exp_sdata [$];

   riscv32i riscv32i_inst (.*);

   bind riscv32i riscv32i_properties riscv32i_properties_inst (
      .clk(clk), .reset(reset), .retire_valid_i(retire_valid_o),
      .store_valid_i(store_valid_o), .halt_i(halt_o), .redirect_i(p2_redirect)
   );

   always #20 clk = ~clk;

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed) & 32'h7fff_ffff;
      return r % n;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                  input logic [xlen-1:0] expected);
      stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, expected));
   endtask

   task automatic push_retire(input logic [xlen-1:0] pc, input logic we,
                              input logic [4:0] rd, input logic [xlen-1:0] data);
      exp_pc.push_back(pc);
      exp_we.push_back(we);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
   endtask

   // random program, forward control flow only
   task automatic build_program();
      logic [xlen-1:0] imm;
      logic [4:0]      rd;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [2:0]      f3;
      logic [6:0]      f7;
      int              span;
      for (int s = 0; s < slots; s++) begin
         kind[s] = kind_e'(rand_below(12));
         rd   = 5'(rand_below(8));
         rs1  = 5'(rand_below(8));
         rs2  = 5'(rand_below(8));
         span = (slots - s < 3) ? slots - s : 3;
         case (kind[s])
            k_lui: begin
               imm = {20'(rand_below(1 << 20)), 12'b0};
               prog[4*s] = {imm[31:12], rd, opc_lui};
            end
            k_addi: begin
               imm = xlen'(rand_below(4096) - 2048);
               prog[4*s] = {imm[11:0], rs1, 3'b000, rd, opc_op_imm};
            end
            k_lw, k_sw: begin
               // x0 base, aligned word in the low 64 bytes
               rs1 = 5'd0;
               imm = xlen'(4 * rand_below(16));
               if (kind[s] == k_lw) prog[4*s] = {imm[11:0], rs1, 3'b010, rd, opc_load};
               else prog[4*s] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
            end
            k_beq, k_bne: begin
               // few registers so equal operands show up
               rs1 = 5'(rand_below(4));
               rs2 = 5'(rand_below(4));
               imm = xlen'(16 * (1 + rand_below(span)));
               f3  = (kind[s] == k_bne) ? 3'b001 : 3'b000;
               prog[4*s] = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
            end
            k_jal: begin
               imm = xlen'(16 * (1 + rand_below(span)));
               prog[4*s] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
            end
            default: begin
               imm = '0;
               f7  = (kind[s] == k_sub) ? 7'b0100000 : 7'b0000000;
               case (kind[s])
                  k_and:   f3 = 3'b111;
                  k_or:    f3 = 3'b110;
                  k_xor:   f3 = 3'b100;
                  default: f3 = 3'b000;
               endcase
               prog[4*s] = {f7, rs2, rs1, f3, rd, opc_op};
            end
         endcase
         f_rd[s]  = rd;
         f_rs1[s] = rs1;
         f_rs2[s] = rs2;
         f_imm[s] = imm;
         for (int n = 1; n < 4; n++) prog[4*s+n] = nop_instr;
      end
      // ebreak ends the program
      prog[4*slots] = 32'h0010_0073;
      for (int n = 1; n < 4; n++) prog[4*slots+n] = nop_instr;
   endtask

   // isa-level model over the slot fields
   task automatic run_model();
      logic [xlen-1:0] regs [32];
      logic [xlen-1:0] mem [dmem_words];
      logic [xlen-1:0] pc;
      logic [xlen-1:0] a;
      logic [xlen-1:0] b;
      logic [xlen-1:0] val;
      logic [xlen-1:0] addr;
      logic            taken;
      logic            writes;
      int              s;
      for (int i = 0; i < 32; i++) regs[i] = '0;
      for (int i = 0; i < dmem_words; i++) mem[i] = '0;
      s = 0;
      while (s < slots) begin
         pc     = xlen'(16 * s);
         a      = regs[f_rs1[s]];
         b      = regs[f_rs2[s]];
         addr   = a + f_imm[s];
         val    = '0;
         taken  = 1'b0;
         writes = 1'b1;
         case (kind[s])
            k_lui:  val = f_imm[s];
            k_addi: val = a + f_imm[s];
            k_add:  val = a + b;
            k_sub:  val = a - b;
            k_and:  val = a & b;
            k_or:   val = a | b;
            k_xor:  val = a ^ b;
            k_lw:   val = mem[addr[9:2]];
            k_sw: begin
               writes = 1'b0;
               exp_saddr.push_back(addr);
               exp_sdata.push_back(b);
               mem[addr[9:2]] = b;
            end
            k_beq: begin
               writes = 1'b0;
               taken  = (a == b);
            end
            k_bne: begin
               writes = 1'b0;
               taken  = (a != b);
            end
            default: begin
               // jal, link is pc + 4
               val   = pc + 32'd4;
               taken = 1'b1;
            end
         endcase
         writes = writes && (f_rd[s] != 5'd0);
         push_retire(pc, writes, f_rd[s], val);
         if (writes) regs[f_rd[s]] = val;
         if (taken) begin
            // word after the branch is already past decode, still retires
            push_retire(pc + 32'd4, 1'b0, 5'd0, '0);
            s = s + int'(f_imm[s] >> 4);
         end else begin
            for (int n = 1; n < 4; n++) push_retire(pc + xlen'(4 * n), 1'b0, 5'd0, '0);
            s++;
         end
      end
   endtask

   task automatic check_retire(input logic [xlen-1:0] pc, input logic we,
                               input logic [4:0] rd, input logic [xlen-1:0] data);
      logic [xlen-1:0] e_pc;
      logic            e_we;
      logic [4:0]      e_rd;
      logic [xlen-1:0] e_data;
      if (exp_pc.size() == 0) begin
         stop_with_failure("an instruction retired after the last expected one");
      end else begin
         e_pc   = exp_pc.pop_front();
         e_we   = exp_we.pop_front();
         e_rd   = exp_rd.pop_front();
         e_data = exp_data.pop_front();
         retire_seen++;
         if (pc !== e_pc) report_mismatch("retire_pc_o", pc, e_pc);
         if (we !== e_we) report_mismatch("retire_we_o", {31'b0, we}, {31'b0, e_we});
         // rd and data only matter for a register write
         if (e_we && (rd !== e_rd)) report_mismatch("retire_rd_o", {27'b0, rd}, {27'b0, e_rd});
         if (e_we && (data !== e_data)) report_mismatch("retire_data_o", data, e_data);
      end
   endtask

   task automatic check_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
      logic [xlen-1:0] e_addr;
      logic [xlen-1:0] e_data;
      if (exp_saddr.size() == 0) begin
         stop_with_failure("a store appeared that the program does not execute");
      end else begin
         e_addr = exp_saddr.pop_front();
         e_data = exp_sdata.pop_front();
         if (addr !== e_addr) report_mismatch("store_addr_o", addr, e_addr);
         if (data !== e_data) report_mismatch("store_data_o", data, e_data);
      end
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if (retire_valid_o) check_retire(retire_pc_o, retire_we_o, retire_rd_o, retire_data_o);
         if (store_valid_o) check_store(store_addr_o, store_data_o);
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         cycles++;
         if (cycles >= max_cycles) begin
            stop_with_failure($sformatf("timeout, no halt within %0d cycles", max_cycles));
         end
      end
   end

   initial begin
      seed        = seed_init;
      clk         = 1'b0;
      reset       = 1'b1;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      cycles      = 0;
      retire_seen = 0;
      build_program();
      run_model();
      model_retires = exp_pc.size();
      // program load needs the core in reset
      for (int w = 0; w < prog_words; w++) begin
         @(posedge clk);
         #2;
         imem_we_i   = 1'b1;
         imem_addr_i = imem_addr_bits'(w);
         imem_data_i = prog[w];
      end
      @(posedge clk);
      #2;
      imem_we_i = 1'b0;
      // then 3 plain reset cycles
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;
      while (!halt_o) @(negedge clk);
      // watch a few halted cycles for stray events
      repeat (4) @(posedge clk);
      if (exp_saddr.size() == 0 && retire_seen == model_retires) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         stop_with_failure("core halted before all expected retire or store events were seen");
      end
   end

endmodule

`default_nettype wire

/* build.f */
src/rv_pkg.sv
src/fetch.sv
src/decode.sv
src/reg_file.sv
src/execute.sv
src/data_mem.sv
src/riscv32i.sv
sim/riscv32i_properties.sv
sim/riscv32i_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the riscv32i testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f \
   --top-module riscv32i_tb -Mdir obj_dir -o riscv32i_sim

./obj_dir/riscv32i_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
